// ==== hw/mcu_ao_pkg.sv ====
// ############################
// Always-on block package
// Widths, register map, vector bit positions and shared types
// ############################

package mcu_ao_pkg;

  localparam int DATA_W       = 32;
  localparam int ADDR_W       = 6;
  localparam int GPIO_W       = 8;
  localparam int NUM_EXT_INT  = 4;
  localparam int FAST_W       = 15;
  localparam int IRQ_SW_BIT   = 3;
  localparam int IRQ_EXT_BIT  = 11;
  localparam int IRQ_FAST_LSB = 16;
  localparam int SYNC_STAGES  = 2;

  // Register word addresses
  typedef enum logic [ADDR_W-1:0] {
    REG_GPIO_OUT         = 6'h00,
    REG_GPIO_OE          = 6'h04,
    REG_GPIO_IN          = 6'h08,
    REG_GPIO_INTR_EN     = 6'h0C,
    REG_GPIO_INTR_STATUS = 6'h10,
    REG_INTR_VECTOR      = 6'h14,
    REG_FAST_INTR_MASK   = 6'h18,
    REG_PD_CTRL          = 6'h1C,
    REG_PD_STATUS        = 6'h20,
    REG_MSIP             = 6'h24
  } reg_addr_e;

  typedef enum logic [2:0] {
    PD_ON,
    PD_ISO,
    PD_RST,
    PD_SWITCH_OFF,
    PD_OFF,
    PD_SWITCH_ON,
    PD_UNISO
  } pd_state_e;

  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } reg_rsp_t;

  typedef struct packed {
    logic [GPIO_W-1:0] out;
    logic [GPIO_W-1:0] oe;
  } gpio_pad_t;

  typedef struct packed {
    logic [GPIO_W-1:0] out;
    logic [GPIO_W-1:0] oe;
    logic [GPIO_W-1:0] intr_en;
  } gpio_cfg_t;

  // One switchable domain
  typedef struct packed {
    logic sw;
    logic iso;
    logic rst_n;
  } pd_ctrl_t;

endpackage

// ==== hw/gpio_bank.sv ====
// ############################
// Always-on GPIO bank
// Pad drive, input sync and rising-edge interrupt status
// ############################

`timescale 1ns/1ps

module gpio_bank
  import mcu_ao_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  gpio_cfg_t         cfg_i,
  input  logic [GPIO_W-1:0] clear_i,
  input  logic [GPIO_W-1:0] gpio_i,
  output gpio_pad_t         pad_o,
  output logic [GPIO_W-1:0] gpio_in_o,
  output logic [GPIO_W-1:0] status_o
);

  logic [SYNC_STAGES-1:0][GPIO_W-1:0] sync_q;
  logic [GPIO_W-1:0]                  prev_q;
  logic [GPIO_W-1:0]                  status_q;
  logic [GPIO_W-1:0]                  rise;
  gpio_pad_t                          pad_q;

  assign gpio_in_o = sync_q[SYNC_STAGES-1];
  assign rise      = gpio_in_o & ~prev_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q   <= '0;
      prev_q   <= '0;
      status_q <= '0;
      pad_q    <= '0;
    end else begin
      sync_q    <= {sync_q[SYNC_STAGES-2:0], gpio_i};
      prev_q    <= gpio_in_o;
      pad_q.out <= cfg_i.out;
      pad_q.oe  <= cfg_i.oe;
      // Clear wins over a new edge
      status_q  <= (status_q | (rise & cfg_i.intr_en)) & ~clear_i;
    end
  end

  assign pad_o    = pad_q;
  assign status_o = status_q;

  a_status_needs_en: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (status_o & ~$past(status_o) & ~$past(cfg_i.intr_en)) == '0);

endmodule

// ==== hw/irq_collector.sv ====
// ############################
// Interrupt collector
// Masks fast sources and registers the core vector
// ############################

`timescale 1ns/1ps

module irq_collector
  import mcu_ao_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic [GPIO_W-1:0]      gpio_status_i,
  input  logic [NUM_EXT_INT-1:0] ext_intr_i,
  input  logic [FAST_W-1:0]      fast_mask_i,
  input  logic                   msip_i,
  output logic [DATA_W-1:0]      irq_o
);

  logic [FAST_W-1:0] fast_src;
  logic [FAST_W-1:0] fast_masked;
  logic [DATA_W-1:0] irq_d;
  logic [DATA_W-1:0] irq_q;

  // Top fast sources are reserved
  assign fast_src    = FAST_W'({gpio_status_i, ext_intr_i});
  assign fast_masked = fast_src & fast_mask_i;

  always_comb begin
    irq_d                             = '0;
    irq_d[IRQ_FAST_LSB +: FAST_W]     = fast_masked;
    irq_d[IRQ_EXT_BIT]                = |fast_masked;
    irq_d[IRQ_SW_BIT]                 = msip_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      irq_q <= '0;
    end else begin
      irq_q <= irq_d;
    end
  end

  assign irq_o = irq_q;

  a_reserved_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    irq_o[DATA_W-1:IRQ_FAST_LSB+NUM_EXT_INT+GPIO_W] == '0 &&
    irq_o[IRQ_FAST_LSB-1:IRQ_EXT_BIT+1] == '0 &&
    irq_o[IRQ_EXT_BIT-1:IRQ_SW_BIT+1] == '0 &&
    irq_o[IRQ_SW_BIT-1:0] == '0);

endmodule

// ==== hw/power_domain_seq.sv ====
// ############################
// Power domain sequencer
// Isolation, reset and switch ordering for one domain
// ############################

`timescale 1ns/1ps

module power_domain_seq
  import mcu_ao_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     off_req_i,
  input  logic     ack_i,
  output pd_ctrl_t pd_o,
  output logic     on_o
);

  pd_state_e state_q;
  pd_state_e state_d;

  // Request is only sampled in the two stable states
  always_comb begin
    state_d = state_q;
    case (state_q)
      PD_ON:         if (off_req_i) state_d = PD_ISO;
      PD_ISO:        state_d = PD_RST;
      PD_RST:        state_d = PD_SWITCH_OFF;
      PD_SWITCH_OFF: if (!ack_i) state_d = PD_OFF;
      PD_OFF:        if (!off_req_i) state_d = PD_SWITCH_ON;
      PD_SWITCH_ON:  if (ack_i) state_d = PD_UNISO;
      PD_UNISO:      state_d = PD_ON;
      default:       state_d = PD_ON;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= PD_ON;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    pd_o = '{sw: 1'b1, iso: 1'b1, rst_n: 1'b0};
    case (state_q)
      PD_ON:         pd_o = '{sw: 1'b1, iso: 1'b0, rst_n: 1'b1};
      PD_ISO:        pd_o = '{sw: 1'b1, iso: 1'b1, rst_n: 1'b1};
      PD_RST:        pd_o = '{sw: 1'b1, iso: 1'b1, rst_n: 1'b0};
      PD_SWITCH_OFF: pd_o = '{sw: 1'b0, iso: 1'b1, rst_n: 1'b0};
      PD_OFF:        pd_o = '{sw: 1'b0, iso: 1'b1, rst_n: 1'b0};
      PD_SWITCH_ON:  pd_o = '{sw: 1'b1, iso: 1'b1, rst_n: 1'b0};
      PD_UNISO:      pd_o = '{sw: 1'b1, iso: 1'b0, rst_n: 1'b0};
      default:       pd_o = '{sw: 1'b1, iso: 1'b1, rst_n: 1'b0};
    endcase
  end

  assign on_o = (state_q == PD_ON);

  a_iso_before_off: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $fell(pd_o.sw) |-> pd_o.iso && $past(pd_o.iso));

endmodule

// ==== hw/ao_reg_ctrl.sv ====
// ############################
// Register controller
// Handshake, address decode and always-on control registers
// ############################

`timescale 1ns/1ps

module ao_reg_ctrl
  import mcu_ao_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              req_valid_i,
  input  reg_req_t          req_i,
  output logic              req_ready_o,
  output logic              rsp_valid_o,
  output reg_rsp_t          rsp_o,
  input  logic              rsp_ready_i,
  input  logic [GPIO_W-1:0] gpio_in_i,
  input  logic [GPIO_W-1:0] gpio_status_i,
  input  logic [DATA_W-1:0] irq_i,
  input  logic              cpu_on_i,
  input  logic              periph_on_i,
  input  logic              core_sleep_i,
  output gpio_cfg_t         gpio_cfg_o,
  output logic [GPIO_W-1:0] gpio_clear_o,
  output logic [FAST_W-1:0] fast_mask_o,
  output logic              msip_o,
  output logic              cpu_off_req_o,
  output logic              periph_off_req_o
);

  logic              rsp_valid_q;
  reg_rsp_t          rsp_q;
  gpio_cfg_t         gpio_cfg_q;
  gpio_cfg_t         gpio_cfg_d;
  logic [FAST_W-1:0] fast_mask_q;
  logic              msip_q;
  logic [1:0]        pd_ctrl_q;
  logic [DATA_W-1:0] rdata;
  logic              err;
  logic              read_only;
  logic              xfer;
  logic              wr;

  assign req_ready_o = ~rsp_valid_q;
  assign xfer        = req_valid_i & req_ready_o;
  assign wr          = xfer & req_i.write & ~err;

  always_comb begin
    rdata     = '0;
    err       = 1'b0;
    read_only = 1'b0;
    case (req_i.addr)
      REG_GPIO_OUT:         rdata = DATA_W'(gpio_cfg_q.out);
      REG_GPIO_OE:          rdata = DATA_W'(gpio_cfg_q.oe);
      REG_GPIO_INTR_EN:     rdata = DATA_W'(gpio_cfg_q.intr_en);
      REG_GPIO_INTR_STATUS: rdata = DATA_W'(gpio_status_i);
      REG_FAST_INTR_MASK:   rdata = DATA_W'(fast_mask_q);
      REG_PD_CTRL:          rdata = DATA_W'(pd_ctrl_q);
      REG_MSIP:             rdata = DATA_W'(msip_q);
      REG_GPIO_IN: begin
        rdata     = DATA_W'(gpio_in_i);
        read_only = 1'b1;
      end
      REG_INTR_VECTOR: begin
        rdata     = irq_i;
        read_only = 1'b1;
      end
      REG_PD_STATUS: begin
        rdata     = DATA_W'({periph_on_i, cpu_on_i});
        read_only = 1'b1;
      end
      default: err = 1'b1;
    endcase
    if (req_i.write && read_only) begin
      err = 1'b1;
    end
  end

  // Next GPIO config goes straight to the bank so pads follow one cycle after transfer
  always_comb begin
    gpio_cfg_d = gpio_cfg_q;
    if (wr) begin
      case (req_i.addr)
        REG_GPIO_OUT:     gpio_cfg_d.out     = req_i.wdata[GPIO_W-1:0];
        REG_GPIO_OE:      gpio_cfg_d.oe      = req_i.wdata[GPIO_W-1:0];
        REG_GPIO_INTR_EN: gpio_cfg_d.intr_en = req_i.wdata[GPIO_W-1:0];
        default:          gpio_cfg_d         = gpio_cfg_q;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
      gpio_cfg_q  <= '0;
      fast_mask_q <= '0;
      msip_q      <= 1'b0;
      pd_ctrl_q   <= '0;
    end else begin
      gpio_cfg_q <= gpio_cfg_d;
      if (xfer) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
      if (wr && req_i.addr == REG_FAST_INTR_MASK) begin
        fast_mask_q <= req_i.wdata[FAST_W-1:0];
      end
      if (wr && req_i.addr == REG_MSIP) begin
        msip_q <= req_i.wdata[0];
      end
      if (wr && req_i.addr == REG_PD_CTRL) begin
        pd_ctrl_q <= req_i.wdata[1:0];
      end
    end
  end

  // Write responses and errors carry zero data
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      rsp_q.rdata <= (err || req_i.write) ? '0 : rdata;
      rsp_q.err   <= err;
    end
  end

  assign rsp_valid_o      = rsp_valid_q;
  assign rsp_o            = rsp_q;
  assign gpio_cfg_o       = gpio_cfg_d;
  assign gpio_clear_o     = (wr && req_i.addr == REG_GPIO_INTR_STATUS) ?
                            req_i.wdata[GPIO_W-1:0] : '0;
  assign fast_mask_o      = fast_mask_q;
  assign msip_o           = msip_q;
  // cpu may only go down while the core sleeps
  assign cpu_off_req_o    = pd_ctrl_q[0] & core_sleep_i;
  assign periph_off_req_o = pd_ctrl_q[1];

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));

  a_rsp_after_xfer: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    xfer |=> rsp_valid_o);

endmodule

// ==== hw/mcu_ao_top.sv ====
// ############################
// Always-on block top level
// Register port, GPIO bank, interrupt vector and power sequencing
// ############################

`timescale 1ns/1ps

module mcu_ao_top
  import mcu_ao_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   req_valid_i,
  input  reg_req_t               req_i,
  output logic                   req_ready_o,
  output logic                   rsp_valid_o,
  output reg_rsp_t               rsp_o,
  input  logic                   rsp_ready_i,
  input  logic [GPIO_W-1:0]      gpio_i,
  output gpio_pad_t              gpio_pad_o,
  input  logic [NUM_EXT_INT-1:0] ext_intr_i,
  input  logic                   core_sleep_i,
  output logic [DATA_W-1:0]      irq_o,
  output pd_ctrl_t               cpu_pd_o,
  input  logic                   cpu_ack_i,
  output pd_ctrl_t               periph_pd_o,
  input  logic                   periph_ack_i
);

  gpio_cfg_t           gpio_cfg;
  logic [GPIO_W-1:0]   gpio_clear;
  logic [GPIO_W-1:0]   gpio_in;
  logic [GPIO_W-1:0]   gpio_status;
  logic [FAST_W-1:0]   fast_mask;
  logic                msip;
  logic                cpu_off_req;
  logic                periph_off_req;
  logic                cpu_on;
  logic                periph_on;

  ao_reg_ctrl i_ao_reg_ctrl (
    .clk_i,
    .arst_n_i,
    .req_valid_i,
    .req_i,
    .req_ready_o,
    .rsp_valid_o,
    .rsp_o,
    .rsp_ready_i,
    .gpio_in_i        (gpio_in),
    .gpio_status_i    (gpio_status),
    .irq_i            (irq_o),
    .cpu_on_i         (cpu_on),
    .periph_on_i      (periph_on),
    .core_sleep_i,
    .gpio_cfg_o       (gpio_cfg),
    .gpio_clear_o     (gpio_clear),
    .fast_mask_o      (fast_mask),
    .msip_o           (msip),
    .cpu_off_req_o    (cpu_off_req),
    .periph_off_req_o (periph_off_req)
  );

  gpio_bank i_gpio_bank (
    .clk_i,
    .arst_n_i,
    .cfg_i     (gpio_cfg),
    .clear_i   (gpio_clear),
    .gpio_i,
    .pad_o     (gpio_pad_o),
    .gpio_in_o (gpio_in),
    .status_o  (gpio_status)
  );

  irq_collector i_irq_collector (
    .clk_i,
    .arst_n_i,
    .gpio_status_i (gpio_status),
    .ext_intr_i,
    .fast_mask_i   (fast_mask),
    .msip_i        (msip),
    .irq_o
  );

  power_domain_seq i_cpu_pd (
    .clk_i,
    .arst_n_i,
    .off_req_i (cpu_off_req),
    .ack_i     (cpu_ack_i),
    .pd_o      (cpu_pd_o),
    .on_o      (cpu_on)
  );

  power_domain_seq i_periph_pd (
    .clk_i,
    .arst_n_i,
    .off_req_i (periph_off_req),
    .ack_i     (periph_ack_i),
    .pd_o      (periph_pd_o),
    .on_o      (periph_on)
  );

endmodule

// ==== sim/tb_mcu_ao_tests.svh ====
// ##############################
// Testbench tasks
// Register access and the test sequences
// ##############################

`ifndef TB_MCU_AO_TESTS_SVH
`define TB_MCU_AO_TESTS_SVH

// One access; lat counts cycles beyond the one-cycle response
task automatic reg_access(input logic wr, input logic [ADDR_W-1:0] addr_v,
                          input logic [DATA_W-1:0] data_v, output reg_rsp_t rsp,
                          output int lat);
  int n;
  n   = 0;
  lat = 0;
  rsp = '0;
  while (!req_ready_o && n < 16) begin
    step();
    n++;
  end
  if (!req_ready_o) begin
    report_problem("register port did not become ready within 16 cycles");
    return;
  end
  req_valid_i = 1'b1;
  req_i       = '{write: wr, addr: addr_v, wdata: data_v};
  step();
  req_valid_i = 1'b0;
  req_i       = '0;
  while (!rsp_valid_o && lat < 16) begin
    step();
    lat++;
  end
  if (!rsp_valid_o) begin
    report_problem("no response arrived within 16 cycles");
    return;
  end
  rsp         = rsp_o;
  rsp_ready_i = 1'b1;
  step();
  rsp_ready_i = 1'b0;
endtask

task automatic reg_write(input logic [ADDR_W-1:0] addr_v, input logic [DATA_W-1:0] data_v);
  reg_rsp_t rsp;
  int       lat;
  reg_access(1'b1, addr_v, data_v, rsp, lat);
  check("write error flag", 0, rsp.err);
endtask

task automatic reg_read(input logic [ADDR_W-1:0] addr_v, output logic [DATA_W-1:0] data_v);
  reg_rsp_t rsp;
  int       lat;
  reg_access(1'b0, addr_v, '0, rsp, lat);
  check("read error flag", 0, rsp.err);
  data_v = rsp.rdata;
endtask

// Records the cycle of each control change of one domain
task automatic trace_power(input logic dom, input logic down,
                           output int t_a, output int t_b, output int t_c);
  pd_ctrl_t pd;
  logic     ack;
  logic     done;
  int       n;
  t_a  = 0;
  t_b  = 0;
  t_c  = 0;
  n    = 0;
  done = 1'b0;
  while (!done && n < 64) begin
    step();
    n++;
    pd  = dom ? periph_pd_o : cpu_pd_o;
    ack = dom ? periph_ack_i : cpu_ack_i;
    if (down) begin
      if (t_a == 0 && pd.iso) t_a = n;
      if (t_b == 0 && !pd.rst_n) t_b = n;
      if (t_c == 0 && !pd.sw) t_c = n;
      done = !pd.sw && !ack;
    end else begin
      if (t_a == 0 && pd.sw) t_a = n;
      if (t_b == 0 && !pd.iso) t_b = n;
      if (t_c == 0 && pd.rst_n) t_c = n;
      done = pd.sw && !pd.iso && pd.rst_n;
    end
  end
  if (!done) begin
    report_problem("power sequence did not complete within 64 cycles");
  end else if (down) begin
    wait_cycles(2);
  end
endtask

task automatic test_gpio_out();
  logic [GPIO_W-1:0] out_v;
  logic [GPIO_W-1:0] oe_v;
  logic [DATA_W-1:0] rd;
  begin_test("gpio_out");
  for (int i = 0; i < 4; i++) begin
    out_v = GPIO_W'(rnd());
    oe_v  = GPIO_W'(rnd());
    reg_write(REG_GPIO_OUT, DATA_W'(out_v));
    check("pad out", out_v, gpio_pad_o.out);
    reg_write(REG_GPIO_OE, DATA_W'(oe_v));
    check("pad oe", oe_v, gpio_pad_o.oe);
    reg_read(REG_GPIO_OUT, rd);
    check("out readback", out_v, rd);
    reg_read(REG_GPIO_OE, rd);
    check("oe readback", oe_v, rd);
  end
  end_test();
endtask

task automatic test_gpio_intr();
  logic [GPIO_W-1:0] en;
  logic [GPIO_W-1:0] pat;
  logic [GPIO_W-1:0] clr;
  logic [GPIO_W-1:0] exp;
  logic [DATA_W-1:0] rd;
  begin_test("gpio_intr");
  reg_write(REG_GPIO_INTR_STATUS, '1);
  exp = '0;
  en  = GPIO_W'(rnd());
  reg_write(REG_GPIO_INTR_EN, DATA_W'(en));
  for (int i = 0; i < 4; i++) begin
    pat    = GPIO_W'(rnd());
    gpio_i = pat;
    wait_cycles(SYNC_STAGES + 1);
    reg_read(REG_GPIO_IN, rd);
    check("gpio_in", pat, rd);
    gpio_i = '0;
    wait_cycles(SYNC_STAGES + 2);
    exp = ref_status(exp, en, pat, '0);
    reg_read(REG_GPIO_INTR_STATUS, rd);
    check("status after edges", exp, rd);
    clr = GPIO_W'(rnd());
    reg_write(REG_GPIO_INTR_STATUS, DATA_W'(clr));
    exp = ref_status(exp, en, '0, clr);
    reg_read(REG_GPIO_INTR_STATUS, rd);
    check("status after clear", exp, rd);
  end
  end_test();
endtask

task automatic test_irq_vector();
  logic [GPIO_W-1:0] pat;
  logic [DATA_W-1:0] rd;
  begin_test("irq_vector");
  reg_write(REG_GPIO_INTR_EN, '1);
  for (int i = 0; i < 4; i++) begin
    irq_mon_en = 1'b0;
    reg_write(REG_GPIO_INTR_STATUS, '1);
    pat    = GPIO_W'(rnd());
    gpio_i = pat;
    wait_cycles(SYNC_STAGES + 2);
    gpio_i = '0;
    wait_cycles(SYNC_STAGES + 2);
    exp_status = pat;
    exp_mask   = FAST_W'(rnd());
    exp_msip   = 1'(rnd());
    reg_write(REG_FAST_INTR_MASK, DATA_W'(exp_mask));
    reg_write(REG_MSIP, DATA_W'(exp_msip));
    ext_intr_i = NUM_EXT_INT'(rnd());
    wait_cycles(2);
    irq_mon_en = 1'b1;
    wait_cycles(4);
    reg_read(REG_INTR_VECTOR, rd);
    check("INTR_VECTOR", ref_irq(exp_mask, ext_intr_i, exp_status, exp_msip), rd);
  end
  irq_mon_en = 1'b0;
  ext_intr_i = '0;
  end_test();
endtask

task automatic test_power();
  int                t_a;
  int                t_b;
  int                t_c;
  logic [DATA_W-1:0] rd;
  begin_test("power");
  core_sleep_i = 1'b0;
  reg_write(REG_PD_CTRL, 32'h1);
  // Awake core keeps the cpu domain on
  for (int i = 0; i < 8; i++) begin
    step();
    check("cpu held on", 3'b101, cpu_pd_o);
  end
  reg_read(REG_PD_STATUS, rd);
  check("status before sleep", 32'h3, rd);
  core_sleep_i = 1'b1;
  trace_power(1'b0, 1'b1, t_a, t_b, t_c);
  check("cpu iso cycle", 1, t_a);
  check("cpu reset cycle", 2, t_b);
  check("cpu switch cycle", 3, t_c);
  reg_read(REG_PD_STATUS, rd);
  check("status cpu off", 32'h2, rd);
  fork
    reg_write(REG_PD_CTRL, 32'h0);
    trace_power(1'b0, 1'b0, t_a, t_b, t_c);
  join
  check("cpu iso off after switch", 1, t_b > t_a);
  check("cpu reset release cycle", t_b + 1, t_c);
  reg_read(REG_PD_STATUS, rd);
  check("status cpu back on", 32'h3, rd);
  core_sleep_i = 1'b0;
  fork
    reg_write(REG_PD_CTRL, 32'h2);
    trace_power(1'b1, 1'b1, t_a, t_b, t_c);
  join
  check("periph reset after iso", t_a + 1, t_b);
  check("periph switch after reset", t_b + 1, t_c);
  check("cpu untouched", 3'b101, cpu_pd_o);
  reg_read(REG_PD_STATUS, rd);
  check("status periph off", 32'h1, rd);
  fork
    reg_write(REG_PD_CTRL, 32'h0);
    trace_power(1'b1, 1'b0, t_a, t_b, t_c);
  join
  check("periph iso off after switch", 1, t_b > t_a);
  check("periph reset release cycle", t_b + 1, t_c);
  reg_read(REG_PD_STATUS, rd);
  check("status periph back on", 32'h3, rd);
  end_test();
endtask

task automatic test_errors();
  logic [ADDR_W-1:0] bad_addr [0:5];
  logic [ADDR_W-1:0] ro_addr [0:2];
  logic [DATA_W-1:0] rd;
  reg_rsp_t          rsp;
  int                lat;
  begin_test("errors");
  reg_write(REG_GPIO_OUT, 32'hA5);
  reg_write(REG_GPIO_OE, 32'h3C);
  reg_write(REG_GPIO_INTR_EN, 32'h0F);
  reg_write(REG_FAST_INTR_MASK, 32'h1234);
  reg_write(REG_MSIP, 32'h1);
  bad_addr = '{6'h28, 6'h2C, 6'h30, 6'h3C, 6'h02, 6'h13};
  ro_addr  = '{REG_GPIO_IN, REG_INTR_VECTOR, REG_PD_STATUS};
  for (int i = 0; i < 6; i++) begin
    for (int w = 0; w < 2; w++) begin
      reg_access(1'(w), bad_addr[i], '1, rsp, lat);
      check("unused address error", 1, rsp.err);
      check("unused address data", 0, rsp.rdata);
    end
  end
  for (int i = 0; i < 3; i++) begin
    reg_access(1'b1, ro_addr[i], '1, rsp, lat);
    check("read-only write error", 1, rsp.err);
    check("read-only write data", 0, rsp.rdata);
  end
  reg_read(REG_GPIO_OUT, rd);
  check("GPIO_OUT kept", 32'hA5, rd);
  reg_read(REG_GPIO_OE, rd);
  check("GPIO_OE kept", 32'h3C, rd);
  reg_read(REG_GPIO_INTR_EN, rd);
  check("GPIO_INTR_EN kept", 32'h0F, rd);
  reg_read(REG_FAST_INTR_MASK, rd);
  check("FAST_INTR_MASK kept", 32'h1234, rd);
  reg_read(REG_MSIP, rd);
  check("MSIP kept", 32'h1, rd);
  reg_read(REG_PD_CTRL, rd);
  check("PD_CTRL kept", 32'h0, rd);
  check("pads kept", 16'hA53C, gpio_pad_o);
  end_test();
endtask

task automatic test_backpressure();
  reg_rsp_t          held;
  logic [DATA_W-1:0] rd;
  int                lat;
  int                hold;
  begin_test("backpressure");
  reg_write(REG_GPIO_OUT, 32'h5A);
  for (int i = 0; i < 3; i++) begin
    reg_access(1'b0, REG_GPIO_OUT, '0, held, lat);
    check("response latency", 0, lat);
  end
  hold        = 3 + int'(rnd() & 32'h7);
  req_valid_i = 1'b1;
  req_i       = '{write: 1'b0, addr: REG_GPIO_OUT, wdata: '0};
  step();
  check("valid one cycle after transfer", 1, rsp_valid_o);
  held = rsp_o;
  check("held read data", 32'h5A, held.rdata);
  // A write waits behind the unaccepted response
  req_i = '{write: 1'b1, addr: REG_GPIO_OUT, wdata: 32'hC3};
  for (int i = 0; i < hold; i++) begin
    step();
    check("valid held", 1, rsp_valid_o);
    check("ready low", 0, req_ready_o);
    check("data stable", held.rdata, rsp_o.rdata);
    check("error stable", held.err, rsp_o.err);
  end
  check("pad out during hold", 32'h5A, gpio_pad_o.out);
  req_valid_i = 1'b0;
  req_i       = '0;
  rsp_ready_i = 1'b1;
  step();
  rsp_ready_i = 1'b0;
  check("valid after accept", 0, rsp_valid_o);
  check("ready after accept", 1, req_ready_o);
  reg_read(REG_GPIO_OUT, rd);
  check("no write during hold", 32'h5A, rd);
  end_test();
endtask

`endif

// ==== sim/tb_mcu_ao.sv ====
// ##############################
// Always-on block testbench
// Clock, reset, ack model, reference models and summary
// ##############################

`timescale 1ns/1ps

module tb_mcu_ao
  import mcu_ao_pkg::*;
();

  localparam int NUM_TESTS = 6;
  localparam int CLK_HALF  = 20;

  logic                   clk_i;
  logic                   arst_n_i;
  logic                   req_valid_i;
  reg_req_t               req_i;
  logic                   req_ready_o;
  logic                   rsp_valid_o;
  reg_rsp_t               rsp_o;
  logic                   rsp_ready_i;
  logic [GPIO_W-1:0]      gpio_i;
  gpio_pad_t              gpio_pad_o;
  logic [NUM_EXT_INT-1:0] ext_intr_i;
  logic                   core_sleep_i;
  logic [DATA_W-1:0]      irq_o;
  pd_ctrl_t               cpu_pd_o;
  logic                   cpu_ack_i;
  pd_ctrl_t               periph_pd_o;
  logic                   periph_ack_i;

  integer            seed;
  string             test_name;
  int                err_cnt;
  int                test_errs;
  int                pass_cnt;
  int                fail_cnt;
  logic              irq_mon_en;
  logic [FAST_W-1:0] exp_mask;
  logic [GPIO_W-1:0] exp_status;
  logic              exp_msip;

  mcu_ao_top i_mcu_ao_top (.*);

  always #CLK_HALF clk_i = ~clk_i;

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  // Expected core vector from the mask, the sources and MSIP
  function automatic logic [DATA_W-1:0] ref_irq(input logic [FAST_W-1:0] mask,
                                                input logic [NUM_EXT_INT-1:0] ext,
                                                input logic [GPIO_W-1:0] status,
                                                input logic msip);
    logic [DATA_W-1:0] vec;
    logic              src;
    vec = '0;
    for (int i = 0; i < FAST_W; i++) begin
      if (i < NUM_EXT_INT) begin
        src = ext[i];
      end else if (i < NUM_EXT_INT + GPIO_W) begin
        src = status[i - NUM_EXT_INT];
      end else begin
        src = 1'b0;
      end
      vec[IRQ_FAST_LSB + i] = src & mask[i];
      if (src && mask[i]) begin
        vec[IRQ_EXT_BIT] = 1'b1;
      end
    end
    vec[IRQ_SW_BIT] = msip;
    return vec;
  endfunction

  // Sticky status after edges and a clear where the clear wins
  function automatic logic [GPIO_W-1:0] ref_status(input logic [GPIO_W-1:0] old,
                                                   input logic [GPIO_W-1:0] en,
                                                   input logic [GPIO_W-1:0] edges,
                                                   input logic [GPIO_W-1:0] clear);
    logic [GPIO_W-1:0] st;
    st = old;
    for (int i = 0; i < GPIO_W; i++) begin
      if (clear[i]) begin
        st[i] = 1'b0;
      end else if (edges[i] && en[i]) begin
        st[i] = 1'b1;
      end
    end
    return st;
  endfunction

  task automatic check(input string what, input logic [DATA_W-1:0] exp,
                       input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("ERR %s %s expected 0x%h actual 0x%h", test_name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic report_problem(input string what);
    $display("%s: %s", test_name, what);
    err_cnt++;
  endtask

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) step();
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = err_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == test_errs) begin
      $display("PASS %s", test_name);
      pass_cnt++;
    end else begin
      $display("FAIL %s with %0d errors", test_name, err_cnt - test_errs);
      fail_cnt++;
    end
  endtask

  `include "tb_mcu_ao_tests.svh"

  // One power switch acknowledge model per domain
  always begin
    @(posedge clk_i);
    #1;
    if (arst_n_i && cpu_pd_o.sw !== cpu_ack_i) begin
      repeat ((rnd() & 32'h7) + 1) @(posedge clk_i);
      #2;
      cpu_ack_i = cpu_pd_o.sw;
    end
  end

  always begin
    @(posedge clk_i);
    #1;
    if (arst_n_i && periph_pd_o.sw !== periph_ack_i) begin
      repeat ((rnd() & 32'h7) + 1) @(posedge clk_i);
      #2;
      periph_ack_i = periph_pd_o.sw;
    end
  end

  // Compares irq_o every cycle while the sources are held
  always @(posedge clk_i) begin
    #1;
    if (irq_mon_en) begin
      check("irq_o", ref_irq(exp_mask, ext_intr_i, exp_status, exp_msip), irq_o);
    end
  end

  initial begin
    repeat (NUM_TESTS * 2000) @(posedge clk_i);
    $display("Watchdog expired before the tests completed");
    $display("Regression failed");
    $finish;
  end

  initial begin
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    rsp_ready_i  = 1'b0;
    gpio_i       = '0;
    ext_intr_i   = '0;
    core_sleep_i = 1'b0;
    cpu_ack_i    = 1'b1;
    periph_ack_i = 1'b1;
    seed         = 32'ha965;
    err_cnt      = 0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    irq_mon_en   = 1'b0;
    exp_mask     = '0;
    exp_status   = '0;
    exp_msip     = 1'b0;
    repeat (10) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;
    step();
    test_gpio_out();
    test_gpio_intr();
    test_irq_vector();
    test_power();
    test_errors();
    test_backpressure();
    $display("Summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== mcu_ao.f ====
+incdir+sim
hw/mcu_ao_pkg.sv
hw/gpio_bank.sv
hw/irq_collector.sv
hw/power_domain_seq.sv
hw/ao_reg_ctrl.sv
hw/mcu_ao_top.sv
sim/tb_mcu_ao.sv
